// ==== logic/mem_map_pkg.sv ====
package mem_map_pkg;

    // byte address as issued by either processor port
    typedef logic [31:0] addr_t;

    // one memory word
    typedef logic [31:0] data_t;

    // byte-write strobe, one bit per byte lane of a word
    typedef logic [$bits(data_t)/8-1:0] strb_t;

    // bank number, bank 0 at address 0 and bank 1 right after it
    typedef logic [0:0] bank_sel_t;

    // word-address width of a bank, 14 bits gives 64 KiB per bank
    localparam int BANK_AW_DEFAULT = 14;

endpackage

// ==== logic/marb_pkg.sv ====
package marb_pkg;

    // which master wins the next same-bank conflict
    typedef enum logic {
        PRIO_INST,
        PRIO_DATA
    } prio_e;

    // owner of a bank for the current cycle
    typedef enum logic [1:0] {
        M_NONE,
        M_INST,
        M_DATA
    } master_t;

endpackage

// ==== logic/addr_decode.sv ====
`timescale 1ns/1ps

module addr_decode #(
    parameter int bank_aw = mem_map_pkg::BANK_AW_DEFAULT
) (
    input  mem_map_pkg::addr_t     addr,
    output mem_map_pkg::bank_sel_t bank_sel,
    output logic [bank_aw-1:0]     word_idx,
    output logic                   out_of_map
);
    import mem_map_pkg::*;

    localparam int ADDR_W = $bits(addr_t);
    // byte offset bits inside a word are dropped
    localparam int WORD_LSB = $clog2($bits(strb_t));
    // first bit above the word index selects the bank
    localparam int BANK_BIT = WORD_LSB + bank_aw;
    // anything set above the bank bit lies past the end of bank 1
    localparam int HIGH_LSB = BANK_BIT + 1;

    assign word_idx = addr[WORD_LSB +: bank_aw];
    assign bank_sel = addr[BANK_BIT];

    assign out_of_map = |addr[ADDR_W-1:HIGH_LSB];

endmodule

// ==== logic/marb_ctrl.sv ====
`timescale 1ns/1ps

module marb_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   imem_en,
    input  mem_map_pkg::bank_sel_t inst_bank_sel,
    input  logic                   inst_out_of_map,
    input  logic                   dmem_en,
    input  mem_map_pkg::bank_sel_t data_bank_sel,
    input  logic                   data_out_of_map,
    input  logic                   dmem_write,
    output logic                   imem_busy,
    output logic                   dmem_busy,
    output logic                   imem_err,
    output logic                   dmem_err,
    output marb_pkg::master_t      bank0_owner,
    output marb_pkg::master_t      bank1_owner,
    output mem_map_pkg::bank_sel_t inst_resp_bank,
    output mem_map_pkg::bank_sel_t data_resp_bank,
    output logic                   inst_resp_vld,
    output logic                   data_resp_vld
);
    import mem_map_pkg::*;
    import marb_pkg::*;

    localparam bank_sel_t BANK0 = 1'b0;
    localparam bank_sel_t BANK1 = 1'b1;

    prio_e prio;

    logic inst_req;
    logic data_req;
    logic conflict;
    logic inst_win;
    logic data_win;

    // data wins ties inside this function, but only one of the two can win a bank
    function automatic master_t bank_owner(
        input bank_sel_t bank,
        input logic      i_win,
        input bank_sel_t i_bank,
        input logic      d_win,
        input bank_sel_t d_bank
    );
        master_t owner;
        owner = M_NONE;
        if (d_win && d_bank == bank) begin
            owner = M_DATA;
        end else if (i_win && i_bank == bank) begin
            owner = M_INST;
        end
        return owner;
    endfunction

    // out-of-map requests never reach a bank
    assign inst_req = imem_en & ~inst_out_of_map;
    assign data_req = dmem_en & ~data_out_of_map;

    assign conflict = inst_req & data_req & (inst_bank_sel == data_bank_sel);

    assign inst_win = inst_req & (~conflict | (prio == PRIO_INST));
    assign data_win = data_req & (~conflict | (prio == PRIO_DATA));

    // loser of a conflict stalls and holds its request
    assign imem_busy = inst_req & ~inst_win;
    assign dmem_busy = data_req & ~data_win;

    assign imem_err = imem_en & inst_out_of_map;
    assign dmem_err = dmem_en & data_out_of_map;

    assign bank0_owner = bank_owner(BANK0, inst_win, inst_bank_sel, data_win, data_bank_sel);
    assign bank1_owner = bank_owner(BANK1, inst_win, inst_bank_sel, data_win, data_bank_sel);

    // priority goes to the loser after every conflict
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prio <= PRIO_DATA;
        end else if (conflict) begin
            prio <= (prio == PRIO_DATA) ? PRIO_INST : PRIO_DATA;
        end
    end

    // read returns one cycle after acceptance, writes return nothing
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_resp_vld  <= 1'b0;
            data_resp_vld  <= 1'b0;
            inst_resp_bank <= BANK0;
            data_resp_bank <= BANK0;
        end else begin
            inst_resp_vld  <= inst_win;
            data_resp_vld  <= data_win & ~dmem_write;
            inst_resp_bank <= inst_bank_sel;
            data_resp_bank <= data_bank_sel;
        end
    end

endmodule

// ==== logic/bank_port.sv ====
`timescale 1ns/1ps

module bank_port #(
    parameter int bank_aw = mem_map_pkg::BANK_AW_DEFAULT
) (
    input  logic               clk,
    input  logic               rstn,
    input  marb_pkg::master_t  owner,
    input  logic [bank_aw-1:0] inst_word_idx,
    input  logic [bank_aw-1:0] data_word_idx,
    input  logic               dmem_write,
    input  mem_map_pkg::strb_t dmem_strb,
    input  mem_map_pkg::data_t dmem_wdata,
    output mem_map_pkg::data_t rdata
);
    import mem_map_pkg::*;
    import marb_pkg::*;

    localparam int DEPTH  = 1 << bank_aw;
    localparam int NBYTES = $bits(strb_t);

    data_t mem [0:DEPTH-1];

    logic [bank_aw-1:0] word_idx;
    logic               wr_en;
    logic               rd_en;

    // instruction master only ever reads
    assign word_idx = (owner == M_DATA) ? data_word_idx : inst_word_idx;
    assign wr_en    = (owner == M_DATA) & dmem_write;
    assign rd_en    = (owner == M_INST) | ((owner == M_DATA) & ~dmem_write);

    // byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (dmem_strb[b]) begin
                    mem[word_idx][b*8 +: 8] <= dmem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // read data registered, held while the bank is idle or writing
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

// ==== logic/resp_mux.sv ====
`timescale 1ns/1ps

module resp_mux (
    input  logic                   clk,
    input  logic                   rstn,
    input  mem_map_pkg::data_t     bank0_rdata,
    input  mem_map_pkg::data_t     bank1_rdata,
    input  mem_map_pkg::bank_sel_t inst_resp_bank,
    input  mem_map_pkg::bank_sel_t data_resp_bank,
    input  logic                   inst_resp_vld,
    input  logic                   data_resp_vld,
    output mem_map_pkg::data_t     imem_rdata,
    output mem_map_pkg::data_t     dmem_rdata
);
    import mem_map_pkg::*;

    data_t inst_sel;
    data_t data_sel;

    // pick the bank that served each master's read
    assign inst_sel = inst_resp_bank[0] ? bank1_rdata : bank0_rdata;
    assign data_sel = data_resp_bank[0] ? bank1_rdata : bank0_rdata;

    // each port keeps its last read word until the next one returns
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            imem_rdata <= '0;
        end else if (inst_resp_vld) begin
            imem_rdata <= inst_sel;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dmem_rdata <= '0;
        end else if (data_resp_vld) begin
            dmem_rdata <= data_sel;
        end
    end

endmodule

// ==== logic/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys #(
    parameter int bank_aw = mem_map_pkg::BANK_AW_DEFAULT
) (
    input  logic               clk,
    input  logic               rstn,
    // instruction port, read only
    input  logic               imem_en,
    input  mem_map_pkg::addr_t imem_addr,
    output logic               imem_busy,
    output logic               imem_err,
    output mem_map_pkg::data_t imem_rdata,
    // data port
    input  logic               dmem_en,
    input  mem_map_pkg::addr_t dmem_addr,
    input  logic               dmem_write,
    input  mem_map_pkg::strb_t dmem_strb,
    input  mem_map_pkg::data_t dmem_wdata,
    output logic               dmem_busy,
    output logic               dmem_err,
    output mem_map_pkg::data_t dmem_rdata
);
    import mem_map_pkg::*;
    import marb_pkg::*;

    bank_sel_t          inst_bank_sel;
    bank_sel_t          data_bank_sel;
    logic [bank_aw-1:0] inst_word_idx;
    logic [bank_aw-1:0] data_word_idx;
    logic               inst_out_of_map;
    logic               data_out_of_map;

    master_t            bank0_owner;
    master_t            bank1_owner;

    bank_sel_t          inst_resp_bank;
    bank_sel_t          data_resp_bank;
    logic               inst_resp_vld;
    logic               data_resp_vld;

    data_t              bank0_rdata;
    data_t              bank1_rdata;

    addr_decode #(
        .bank_aw    (bank_aw)
    ) i_inst_decode (
        .addr       (imem_addr),
        .bank_sel   (inst_bank_sel),
        .word_idx   (inst_word_idx),
        .out_of_map (inst_out_of_map)
    );

    addr_decode #(
        .bank_aw    (bank_aw)
    ) i_data_decode (
        .addr       (dmem_addr),
        .bank_sel   (data_bank_sel),
        .word_idx   (data_word_idx),
        .out_of_map (data_out_of_map)
    );

    marb_ctrl i_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .imem_en         (imem_en),
        .inst_bank_sel   (inst_bank_sel),
        .inst_out_of_map (inst_out_of_map),
        .dmem_en         (dmem_en),
        .data_bank_sel   (data_bank_sel),
        .data_out_of_map (data_out_of_map),
        .dmem_write      (dmem_write),
        .imem_busy       (imem_busy),
        .dmem_busy       (dmem_busy),
        .imem_err        (imem_err),
        .dmem_err        (dmem_err),
        .bank0_owner     (bank0_owner),
        .bank1_owner     (bank1_owner),
        .inst_resp_bank  (inst_resp_bank),
        .data_resp_bank  (data_resp_bank),
        .inst_resp_vld   (inst_resp_vld),
        .data_resp_vld   (data_resp_vld)
    );

    bank_port #(
        .bank_aw       (bank_aw)
    ) i_bank0 (
        .clk           (clk),
        .rstn          (rstn),
        .owner         (bank0_owner),
        .inst_word_idx (inst_word_idx),
        .data_word_idx (data_word_idx),
        .dmem_write    (dmem_write),
        .dmem_strb     (dmem_strb),
        .dmem_wdata    (dmem_wdata),
        .rdata         (bank0_rdata)
    );

    bank_port #(
        .bank_aw       (bank_aw)
    ) i_bank1 (
        .clk           (clk),
        .rstn          (rstn),
        .owner         (bank1_owner),
        .inst_word_idx (inst_word_idx),
        .data_word_idx (data_word_idx),
        .dmem_write    (dmem_write),
        .dmem_strb     (dmem_strb),
        .dmem_wdata    (dmem_wdata),
        .rdata         (bank1_rdata)
    );

    resp_mux i_resp (
        .clk            (clk),
        .rstn           (rstn),
        .bank0_rdata    (bank0_rdata),
        .bank1_rdata    (bank1_rdata),
        .inst_resp_bank (inst_resp_bank),
        .data_resp_bank (data_resp_bank),
        .inst_resp_vld  (inst_resp_vld),
        .data_resp_vld  (data_resp_vld),
        .imem_rdata     (imem_rdata),
        .dmem_rdata     (dmem_rdata)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_map_pkg::*;

    localparam int BANK_AW       = 6;
    localparam int RESET_TIMEOUT = 20;
    localparam int MAX_CYCLES    = 200;

    logic  clk;
    logic  rstn;
    logic  imem_en;
    addr_t imem_addr;
    logic  imem_busy;
    logic  imem_err;
    data_t imem_rdata;
    logic  dmem_en;
    addr_t dmem_addr;
    logic  dmem_write;
    strb_t dmem_strb;
    data_t dmem_wdata;
    logic  dmem_busy;
    logic  dmem_err;
    data_t dmem_rdata;

    // fields of the current stimulus record
    logic  f_ien;
    addr_t f_iaddr;
    logic  f_den;
    addr_t f_daddr;
    logic  f_dwr;
    strb_t f_dstrb;
    data_t f_dwdata;
    logic  f_ibusy;
    logic  f_ierr;
    logic  f_dbusy;
    logic  f_derr;
    logic  f_ichk;
    data_t f_iexp;
    logic  f_dchk;
    data_t f_dexp;

    // read data of the previous record, accepted at the last edge
    logic  pend_ichk;
    data_t pend_iexp;
    logic  pend_dchk;
    data_t pend_dexp;

    // read data one cycle after acceptance, checked in the current cycle
    logic  due_ichk;
    data_t due_iexp;
    logic  due_dchk;
    data_t due_dexp;

    int fd;
    int seed = 7491;
    int wait_cnt;
    int cycle_cnt;
    bit eof_seen;
    bit found;

    tb_clk_gen #(
        .period_ns    (40),
        .reset_cycles (4)
    ) i_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    mem_subsys #(
        .bank_aw    (BANK_AW)
    ) i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .imem_en    (imem_en),
        .imem_addr  (imem_addr),
        .imem_busy  (imem_busy),
        .imem_err   (imem_err),
        .imem_rdata (imem_rdata),
        .dmem_en    (dmem_en),
        .dmem_addr  (dmem_addr),
        .dmem_write (dmem_write),
        .dmem_strb  (dmem_strb),
        .dmem_wdata (dmem_wdata),
        .dmem_busy  (dmem_busy),
        .dmem_err   (dmem_err),
        .dmem_rdata (dmem_rdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
            abort_run("handshake flag differs from the expected value");
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            abort_run("read data differs from the expected word");
        end
    endtask

    // skips comment and blank lines
    // got stays low at end of file
    task automatic read_record(output bit got);
        string line;
        int    n;
        got = 1'b0;
        while (!got && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f_ien, f_iaddr, f_den, f_daddr, f_dwr, f_dstrb, f_dwdata,
                            f_ibusy, f_ierr, f_dbusy, f_derr,
                            f_ichk, f_iexp, f_dchk, f_dexp);
                if (n != 15) begin
                    abort_run($sformatf("stimulus line has %0d fields instead of 15", n));
                end
                got = 1'b1;
            end
        end
    endtask

    task automatic load_idle();
        f_ien    = 1'b0;
        f_iaddr  = '0;
        f_den    = 1'b0;
        f_daddr  = '0;
        f_dwr    = 1'b0;
        f_dstrb  = '0;
        f_dwdata = '0;
        f_ibusy  = 1'b0;
        f_ierr   = 1'b0;
        f_dbusy  = 1'b0;
        f_derr   = 1'b0;
        f_ichk   = 1'b0;
        f_dchk   = 1'b0;
    endtask

    // drive at the rising edge and check in the middle of the cycle
    task automatic run_cycle();
        @(posedge clk);
        imem_en    <= f_ien;
        imem_addr  <= f_iaddr;
        dmem_en    <= f_den;
        dmem_addr  <= f_daddr;
        dmem_write <= f_dwr;
        dmem_strb  <= f_dstrb;
        dmem_wdata <= f_dwdata;
        @(negedge clk);
        check_flag("imem_busy", f_ibusy, imem_busy);
        check_flag("imem_err", f_ierr, imem_err);
        check_flag("dmem_busy", f_dbusy, dmem_busy);
        check_flag("dmem_err", f_derr, dmem_err);
        if (due_ichk) begin
            check_data("imem_rdata", due_iexp, imem_rdata);
        end
        if (due_dchk) begin
            check_data("dmem_rdata", due_dexp, dmem_rdata);
        end
        due_ichk  = pend_ichk;
        due_iexp  = pend_iexp;
        due_dchk  = pend_dchk;
        due_dexp  = pend_dexp;
        pend_ichk = f_ichk;
        pend_iexp = f_iexp;
        pend_dchk = f_dchk;
        pend_dexp = f_dexp;
    endtask

    initial begin
        imem_en    = 1'b0;
        imem_addr  = '0;
        dmem_en    = 1'b0;
        dmem_addr  = '0;
        dmem_write = 1'b0;
        dmem_strb  = '0;
        dmem_wdata = '0;
        pend_ichk  = 1'b0;
        pend_iexp  = '0;
        pend_dchk  = 1'b0;
        pend_dexp  = '0;
        due_ichk   = 1'b0;
        due_iexp   = '0;
        due_dchk   = 1'b0;
        due_dexp   = '0;
        eof_seen   = 1'b0;
        cycle_cnt  = 0;
        wait_cnt   = 0;

        while (rstn !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rstn !== 1'b1) begin
            abort_run("reset was not released in time");
        end

        // idle state straight out of reset
        check_flag("imem_busy", 1'b0, imem_busy);
        check_flag("dmem_busy", 1'b0, dmem_busy);
        check_data("imem_rdata", '0, imem_rdata);
        check_data("dmem_rdata", '0, dmem_rdata);

        fd = $fopen("tb/mem_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open stimulus file tb/mem_stimulus.txt");
        end

        while (!eof_seen && cycle_cnt < MAX_CYCLES) begin
            read_record(found);
            if (!found) begin
                eof_seen = 1'b1;
            end else begin
                run_cycle();
                cycle_cnt++;
            end
        end
        $fclose(fd);

        if (!eof_seen) begin
            abort_run("stimulus file did not end within the cycle limit");
        end else begin
            // two idle cycles let the last read return
            load_idle();
            run_cycle();
            run_cycle();
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== tb/mem_stimulus.txt ====
# ien iaddr den daddr dwr dstrb dwdata | ibusy ierr dbusy derr | ichk iexp dchk dexp (hex)
# busy and err are for the same cycle, the chk words are checked one cycle later
0 00000000 0 00000000 0 0 00000000  0 0 0 0  1 00000000 1 00000000
0 00000000 1 00000004 1 f 11223344  0 0 0 0  0 00000000 0 00000000
0 00000000 1 00000004 0 0 00000000  0 0 0 0  0 00000000 1 11223344
0 00000000 1 00000004 1 5 aabbccdd  0 0 0 0  0 00000000 1 11223344
0 00000000 1 00000004 0 0 00000000  0 0 0 0  0 00000000 1 11bb33dd
0 00000000 1 00000004 1 8 5a000000  0 0 0 0  0 00000000 0 00000000
0 00000000 1 00000004 0 0 00000000  0 0 0 0  0 00000000 1 5abb33dd
0 00000000 1 00000004 1 2 0000ee00  0 0 0 0  0 00000000 0 00000000
0 00000000 1 00000004 0 0 00000000  0 0 0 0  0 00000000 1 5abbeedd
0 00000000 1 00000020 1 f cafe0001  0 0 0 0  0 00000000 0 00000000
0 00000000 1 00000120 1 f beef0101  0 0 0 0  0 00000000 0 00000000
1 00000020 0 00000000 0 0 00000000  0 0 0 0  1 cafe0001 0 00000000
1 00000120 0 00000000 0 0 00000000  0 0 0 0  1 beef0101 0 00000000
0 00000000 0 00000000 0 0 00000000  0 0 0 0  1 beef0101 1 5abbeedd
0 00000000 0 00000000 0 0 00000000  0 0 0 0  1 beef0101 1 5abbeedd
0 00000000 1 00000140 1 f 01234567  0 0 0 0  0 00000000 0 00000000
0 00000000 1 00000044 1 f 76543210  0 0 0 0  0 00000000 0 00000000
1 00000020 1 00000140 0 0 00000000  0 0 0 0  1 cafe0001 1 01234567
1 00000120 1 00000044 0 0 00000000  0 0 0 0  1 beef0101 1 76543210
1 00000004 1 00000144 1 f 89abcdef  0 0 0 0  1 5abbeedd 1 76543210
1 00000020 1 00000004 0 0 00000000  1 0 0 0  0 00000000 1 5abbeedd
1 00000020 1 00000044 0 0 00000000  0 0 1 0  1 cafe0001 0 00000000
1 00000004 1 00000044 0 0 00000000  1 0 0 0  0 00000000 1 76543210
1 00000004 0 00000000 0 0 00000000  0 0 0 0  1 5abbeedd 0 00000000
1 00000120 1 00000140 0 0 00000000  0 0 1 0  1 beef0101 1 76543210
1 00000140 1 00000144 0 0 00000000  1 0 0 0  1 beef0101 1 89abcdef
1 00000140 1 00000144 1 f 13579bdf  0 0 1 0  1 01234567 1 89abcdef
0 00000000 1 00000144 1 f 13579bdf  0 0 0 0  1 01234567 0 00000000
0 00000000 1 00000144 0 0 00000000  0 0 0 0  0 00000000 1 13579bdf
0 00000000 1 00000204 1 f deadbeef  0 0 0 1  0 00000000 1 13579bdf
1 00000300 1 00000004 0 0 00000000  0 1 0 0  1 01234567 1 5abbeedd
1 00000400 1 fffffffc 0 0 00000000  0 1 0 1  1 01234567 1 5abbeedd
1 00000204 1 00000020 0 0 00000000  0 1 0 0  1 01234567 1 cafe0001
1 00000004 0 00000000 0 0 00000000  0 0 0 0  1 5abbeedd 1 cafe0001

// ==== list.f ====
logic/mem_map_pkg.sv
logic/marb_pkg.sv
logic/addr_decode.sv
logic/marb_ctrl.sv
logic/bank_port.sv
logic/resp_mux.sv
logic/mem_subsys.sv
tb/tb_clk_gen.sv
tb/tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the memory subsystem testbench with Verilator and run it
# exit status is zero only when the simulation ends without a fatal error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module tb_mem_subsys \
    -f list.f \
    -o sim_mem_subsys \
    && ./obj_dir/sim_mem_subsys \
    || { echo "simulation did not complete successfully"; exit 1; }
